// ==== verilog/core_pkg.sv ====
// core widths, opcodes, funct codes, alu and forwarding selects, instruction word views
package core_pkg;

	localparam int xlen = 64;
	localparam int ilen = 32;
	localparam int reg_addr_w = 5;

	// major opcodes of the supported subset
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;

	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	// doubleword width for ld/sd
	localparam logic [2:0] f3_dword = 3'b011;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt = 7'b0100000;

	// five operations need a three bit code
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor
	} alu_op_t;

	// operand source in execute
	typedef enum logic [1:0] {
		fwd_reg,
		fwd_mem,
		fwd_wb
	} fwd_sel_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_view_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_view_t;

	// r/i view carries the i immediate in funct7 and rs2
	typedef union packed {
		r_view_t r;
		s_view_t s;
	} instr_u;

endpackage

// ==== verilog/fetch_stage.sv ====
// program counter and if/id pipeline register
`timescale 1ns/1ns

module fetch_stage import core_pkg::*; #(
	parameter logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            stall,
	output logic [xlen-1:0] inst_addr,
	input  logic [ilen-1:0] inst_data,
	output instr_u          id_instr,
	output logic [xlen-1:0] id_pc,
	output logic            id_valid
);

	logic [xlen-1:0] pc;

	assign inst_addr = pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= reset_pc;
			id_valid <= 1'b0;
		end else if (!stall) begin
			pc <= pc + xlen'(4);
			id_valid <= 1'b1;
		end
	end

	// held along with the pc while decode waits on a load
	always_ff @(posedge clock) begin
		if (!stall) begin
			id_instr <= inst_data;
			id_pc <= pc;
		end
	end

endmodule

// ==== verilog/decode_stage.sv ====
// instruction decode, immediate generation and id/ex pipeline register
`timescale 1ns/1ns

module decode_stage import core_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  stall,
	input  instr_u                id_instr,
	input  logic [xlen-1:0]       id_pc,
	input  logic                  id_valid,
	output logic [reg_addr_w-1:0] rs1_addr,
	output logic [reg_addr_w-1:0] rs2_addr,
	input  logic [xlen-1:0]       rs1_data,
	input  logic [xlen-1:0]       rs2_data,
	output logic                  ex_valid,
	output logic                  ex_load,
	output logic                  ex_store,
	output logic                  ex_we,
	output logic [reg_addr_w-1:0] ex_rd,
	output logic [reg_addr_w-1:0] ex_rs1,
	output logic [reg_addr_w-1:0] ex_rs2,
	output alu_op_t               ex_alu_op,
	output logic                  ex_use_imm,
	output logic [xlen-1:0]       ex_imm,
	output logic [xlen-1:0]       ex_a,
	output logic [xlen-1:0]       ex_b,
	output logic [xlen-1:0]       ex_pc
);

	logic is_reg;
	logic is_imm;
	logic is_load;
	logic is_store;
	logic use_imm;
	logic dec_we;
	alu_op_t dec_alu_op;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;

	// anything outside the subset stays a valid no-op
	always_comb begin
		is_reg = 1'b0;
		is_imm = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		dec_alu_op = alu_add;
		if (id_valid) begin
			case (id_instr.r.opcode)
				op_reg: begin
					is_reg = 1'b1;
					case ({id_instr.r.funct7, id_instr.r.funct3})
						{f7_base, f3_add_sub}: dec_alu_op = alu_add;
						{f7_alt, f3_add_sub}: dec_alu_op = alu_sub;
						{f7_base, f3_xor}: dec_alu_op = alu_xor;
						{f7_base, f3_or}: dec_alu_op = alu_or;
						{f7_base, f3_and}: dec_alu_op = alu_and;
						default: is_reg = 1'b0;
					endcase
				end
				op_imm: is_imm = (id_instr.r.funct3 == f3_add_sub);
				op_load: is_load = (id_instr.r.funct3 == f3_dword);
				op_store: is_store = (id_instr.s.funct3 == f3_dword);
				default: ;
			endcase
		end
	end

	assign use_imm = is_imm | is_load | is_store;
	assign dec_we = (is_reg | is_imm | is_load) && (id_instr.r.rd != '0);

	// unused source fields read as x0 so they never stall or forward
	assign rs1_addr = (is_reg | use_imm) ? id_instr.r.rs1 : '0;
	assign rs2_addr = (is_reg | is_store) ? id_instr.r.rs2 : '0;

	assign imm_i = {{(xlen-12){id_instr.r.funct7[6]}}, id_instr.r.funct7, id_instr.r.rs2};
	assign imm_s = {{(xlen-12){id_instr.s.imm_hi[6]}}, id_instr.s.imm_hi, id_instr.s.imm_lo};

	// bubble on stall
	always_ff @(posedge clock) begin
		if (reset || stall) begin
			ex_valid <= 1'b0;
			ex_load <= 1'b0;
			ex_store <= 1'b0;
			ex_we <= 1'b0;
		end else begin
			ex_valid <= id_valid;
			ex_load <= is_load;
			ex_store <= is_store;
			ex_we <= dec_we;
		end
	end

	always_ff @(posedge clock) begin
		ex_rd <= id_instr.r.rd;
		ex_rs1 <= rs1_addr;
		ex_rs2 <= rs2_addr;
		ex_alu_op <= dec_alu_op;
		ex_use_imm <= use_imm;
		ex_imm <= is_store ? imm_s : imm_i;
		ex_a <= rs1_data;
		ex_b <= rs2_data;
		ex_pc <= id_pc;
	end

endmodule

// ==== verilog/regfile.sv ====
// 32 x 64 register file, two read ports with write-first bypass
`timescale 1ns/1ns

module regfile import core_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [reg_addr_w-1:0] rs1_addr,
	input  logic [reg_addr_w-1:0] rs2_addr,
	output logic [xlen-1:0]       rs1_data,
	output logic [xlen-1:0]       rs2_data,
	input  logic                  wb_we,
	input  logic [reg_addr_w-1:0] wb_rd,
	input  logic [xlen-1:0]       wb_data
);

	logic [xlen-1:0] regs [32];

	// x0 is never written
	always_ff @(posedge clock) begin
		if (!reset && wb_we && wb_rd != '0)
			regs[wb_rd] <= wb_data;
	end

	// same-cycle write wins over the stored value
	assign rs1_data = (rs1_addr == '0) ? '0 :
		(wb_we && wb_rd == rs1_addr) ? wb_data : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 :
		(wb_we && wb_rd == rs2_addr) ? wb_data : regs[rs2_addr];

endmodule

// ==== verilog/hazard_unit.sv ====
// load-use stall detection and forwarding source selection
`timescale 1ns/1ns

module hazard_unit import core_pkg::*; (
	input  logic [reg_addr_w-1:0] rs1_addr,
	input  logic [reg_addr_w-1:0] rs2_addr,
	input  logic                  ex_load,
	input  logic [reg_addr_w-1:0] ex_rd,
	input  logic [reg_addr_w-1:0] ex_rs1,
	input  logic [reg_addr_w-1:0] ex_rs2,
	input  logic                  mem_we,
	input  logic [reg_addr_w-1:0] mem_rd,
	input  logic                  wb_we,
	input  logic [reg_addr_w-1:0] wb_rd,
	output logic                  stall,
	output fwd_sel_t              fwd_a,
	output fwd_sel_t              fwd_b
);

	// load data only exists from writeback on, so one bubble is enough
	assign stall = ex_load && (ex_rd != '0) &&
		(ex_rd == rs1_addr || ex_rd == rs2_addr);

	// youngest producer wins
	function automatic fwd_sel_t pick_source(logic [reg_addr_w-1:0] src, logic m_we,
			logic [reg_addr_w-1:0] m_rd, logic w_we, logic [reg_addr_w-1:0] w_rd);
		if (src == '0)
			return fwd_reg;
		else if (m_we && m_rd == src)
			return fwd_mem;
		else if (w_we && w_rd == src)
			return fwd_wb;
		else
			return fwd_reg;
	endfunction

	assign fwd_a = pick_source(ex_rs1, mem_we, mem_rd, wb_we, wb_rd);
	assign fwd_b = pick_source(ex_rs2, mem_we, mem_rd, wb_we, wb_rd);

endmodule

// ==== verilog/execute_stage.sv ====
// forwarding muxes, alu and ex/mem pipeline register
`timescale 1ns/1ns

module execute_stage import core_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  ex_valid,
	input  logic                  ex_load,
	input  logic                  ex_store,
	input  logic                  ex_we,
	input  logic [reg_addr_w-1:0] ex_rd,
	input  alu_op_t               ex_alu_op,
	input  logic                  ex_use_imm,
	input  logic [xlen-1:0]       ex_imm,
	input  logic [xlen-1:0]       ex_a,
	input  logic [xlen-1:0]       ex_b,
	input  logic [xlen-1:0]       ex_pc,
	input  fwd_sel_t              fwd_a,
	input  fwd_sel_t              fwd_b,
	input  logic [xlen-1:0]       wb_data,
	output logic                  mem_valid,
	output logic                  mem_load,
	output logic                  mem_store,
	output logic                  mem_we,
	output logic [reg_addr_w-1:0] mem_rd,
	output logic [xlen-1:0]       mem_result,
	output logic [xlen-1:0]       mem_store_data,
	output logic [xlen-1:0]       mem_pc
);

	logic [xlen-1:0] src_a;
	logic [xlen-1:0] src_b;
	logic [xlen-1:0] operand_b;
	logic [xlen-1:0] alu_result;

	function automatic logic [xlen-1:0] forward(fwd_sel_t sel, logic [xlen-1:0] rf_value,
			logic [xlen-1:0] mem_value, logic [xlen-1:0] wb_value);
		case (sel)
			fwd_mem: return mem_value;
			fwd_wb: return wb_value;
			default: return rf_value;
		endcase
	endfunction

	assign src_a = forward(fwd_a, ex_a, mem_result, wb_data);
	assign src_b = forward(fwd_b, ex_b, mem_result, wb_data);
	assign operand_b = ex_use_imm ? ex_imm : src_b;

	// loads and stores come through here as add, giving the address
	always_comb begin
		case (ex_alu_op)
			alu_sub: alu_result = src_a - operand_b;
			alu_and: alu_result = src_a & operand_b;
			alu_or: alu_result = src_a | operand_b;
			alu_xor: alu_result = src_a ^ operand_b;
			default: alu_result = src_a + operand_b;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_valid <= 1'b0;
			mem_load <= 1'b0;
			mem_store <= 1'b0;
			mem_we <= 1'b0;
		end else begin
			mem_valid <= ex_valid;
			mem_load <= ex_load;
			mem_store <= ex_store;
			mem_we <= ex_we;
		end
	end

	always_ff @(posedge clock) begin
		mem_rd <= ex_rd;
		mem_result <= alu_result;
		mem_store_data <= src_b;
		mem_pc <= ex_pc;
	end

endmodule

// ==== verilog/memory_stage.sv ====
// doubleword data memory, load/store access and mem/wb register
`timescale 1ns/1ns

module memory_stage import core_pkg::*; #(
	parameter int dmem_depth = 64
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  mem_valid,
	input  logic                  mem_load,
	input  logic                  mem_store,
	input  logic                  mem_we,
	input  logic [reg_addr_w-1:0] mem_rd,
	input  logic [xlen-1:0]       mem_result,
	input  logic [xlen-1:0]       mem_store_data,
	input  logic [xlen-1:0]       mem_pc,
	output logic                  wb_valid,
	output logic                  wb_we,
	output logic [reg_addr_w-1:0] wb_rd,
	output logic [xlen-1:0]       wb_data,
	output logic [xlen-1:0]       wb_pc
);

	localparam int idx_w = $clog2(dmem_depth);

	logic [xlen-1:0] dmem [dmem_depth];
	logic [idx_w-1:0] idx;
	logic [xlen-1:0] load_data;

	// doubleword index, low three address bits ignored
	assign idx = mem_result[idx_w+2:3];
	assign load_data = dmem[idx];

	always_ff @(posedge clock) begin
		if (mem_valid && mem_store)
			dmem[idx] <= mem_store_data;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid <= 1'b0;
			wb_we <= 1'b0;
		end else begin
			wb_valid <= mem_valid;
			wb_we <= mem_valid && mem_we;
		end
	end

	always_ff @(posedge clock) begin
		wb_rd <= mem_rd;
		wb_data <= mem_load ? load_data : mem_result;
		wb_pc <= mem_pc;
	end

endmodule

// ==== verilog/pipeline_top.sv ====
// five-stage pipeline top level with retire port
`timescale 1ns/1ns

module pipeline_top import core_pkg::*; #(
	parameter logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000,
	parameter int              dmem_depth = 64
) (
	input  logic                  clock,
	input  logic                  reset,
	output logic [xlen-1:0]       inst_addr,
	input  logic [ilen-1:0]       inst_data,
	output logic                  retire_valid,
	output logic [xlen-1:0]       retire_pc,
	output logic                  retire_we,
	output logic [reg_addr_w-1:0] retire_rd,
	output logic [xlen-1:0]       retire_data
);

	logic stall;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;

	// if/id
	instr_u id_instr;
	logic [xlen-1:0] id_pc;
	logic id_valid;

	logic [reg_addr_w-1:0] rs1_addr;
	logic [reg_addr_w-1:0] rs2_addr;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;

	// id/ex
	logic ex_valid;
	logic ex_load;
	logic ex_store;
	logic ex_we;
	logic [reg_addr_w-1:0] ex_rd;
	logic [reg_addr_w-1:0] ex_rs1;
	logic [reg_addr_w-1:0] ex_rs2;
	alu_op_t ex_alu_op;
	logic ex_use_imm;
	logic [xlen-1:0] ex_imm;
	logic [xlen-1:0] ex_a;
	logic [xlen-1:0] ex_b;
	logic [xlen-1:0] ex_pc;

	// ex/mem
	logic mem_valid;
	logic mem_load;
	logic mem_store;
	logic mem_we;
	logic [reg_addr_w-1:0] mem_rd;
	logic [xlen-1:0] mem_result;
	logic [xlen-1:0] mem_store_data;
	logic [xlen-1:0] mem_pc;

	// mem/wb
	logic wb_valid;
	logic wb_we;
	logic [reg_addr_w-1:0] wb_rd;
	logic [xlen-1:0] wb_data;
	logic [xlen-1:0] wb_pc;

	fetch_stage #(
		.reset_pc(reset_pc)
	) fetch (
		.clock(clock), .reset(reset), .stall(stall),
		.inst_addr(inst_addr), .inst_data(inst_data),
		.id_instr(id_instr), .id_pc(id_pc), .id_valid(id_valid)
	);

	decode_stage decode (
		.clock(clock), .reset(reset), .stall(stall),
		.id_instr(id_instr), .id_pc(id_pc), .id_valid(id_valid),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.ex_valid(ex_valid), .ex_load(ex_load), .ex_store(ex_store), .ex_we(ex_we),
		.ex_rd(ex_rd), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
		.ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm), .ex_imm(ex_imm),
		.ex_a(ex_a), .ex_b(ex_b), .ex_pc(ex_pc)
	);

	regfile rf (
		.clock(clock), .reset(reset),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	hazard_unit hazard (
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.ex_load(ex_load), .ex_rd(ex_rd), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
		.mem_we(mem_we), .mem_rd(mem_rd),
		.wb_we(wb_we), .wb_rd(wb_rd),
		.stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	execute_stage execute (
		.clock(clock), .reset(reset),
		.ex_valid(ex_valid), .ex_load(ex_load), .ex_store(ex_store), .ex_we(ex_we),
		.ex_rd(ex_rd), .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm),
		.ex_imm(ex_imm), .ex_a(ex_a), .ex_b(ex_b), .ex_pc(ex_pc),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .wb_data(wb_data),
		.mem_valid(mem_valid), .mem_load(mem_load), .mem_store(mem_store),
		.mem_we(mem_we), .mem_rd(mem_rd), .mem_result(mem_result),
		.mem_store_data(mem_store_data), .mem_pc(mem_pc)
	);

	memory_stage #(
		.dmem_depth(dmem_depth)
	) memory (
		.clock(clock), .reset(reset),
		.mem_valid(mem_valid), .mem_load(mem_load), .mem_store(mem_store),
		.mem_we(mem_we), .mem_rd(mem_rd), .mem_result(mem_result),
		.mem_store_data(mem_store_data), .mem_pc(mem_pc),
		.wb_valid(wb_valid), .wb_we(wb_we), .wb_rd(wb_rd),
		.wb_data(wb_data), .wb_pc(wb_pc)
	);

	// writeback is the retire point
	assign retire_valid = wb_valid;
	assign retire_pc = wb_pc;
	assign retire_we = wb_we;
	assign retire_rd = wb_rd;
	assign retire_data = wb_data;

endmodule

// ==== verification/pipeline_properties.sv ====
// bound assertions on reset, fetch hold during stall and the retire port
`timescale 1ns/1ns

module pipeline_properties import core_pkg::*; (
	input logic                  clock,
	input logic                  reset,
	input logic                  stall,
	input logic [xlen-1:0]       inst_addr,
	input logic                  retire_valid,
	input logic                  retire_we,
	input logic [reg_addr_w-1:0] retire_rd
);

	// nothing leaves writeback right after a reset cycle
	quiet_after_reset: assert property (@(posedge clock) reset |=> !retire_valid)
		else $error("retire_valid high in the cycle after reset");

	// a stalled fetch keeps its address
	fetch_held: assert property (@(posedge clock) disable iff (reset)
		stall |=> $stable(inst_addr))
		else $error("inst_addr moved during a load-use stall");

	// x0 is never a write target on the retire port
	no_x0_write: assert property (@(posedge clock) disable iff (reset)
		retire_we |-> retire_rd != '0)
		else $error("retire_we high with retire_rd equal to zero");

endmodule

bind pipeline_top pipeline_properties props (
	.clock(clock), .reset(reset), .stall(stall), .inst_addr(inst_addr),
	.retire_valid(retire_valid), .retire_we(retire_we), .retire_rd(retire_rd)
);

// ==== verification/pipeline_tb.sv ====
// pipeline testbench: clock, reset, instruction memory, program generator, model and checks
`timescale 1ns/1ns

module pipeline_tb import core_pkg::*; ();

	localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;
	localparam int dmem_depth = 64;
	localparam int imem_depth = 128;
	localparam logic [ilen-1:0] nop_word = 32'h0000_0013;

	// program lengths, used for the timeout
	localparam int prologue_len = 15;
	localparam int reset_len = 8;
	localparam int random_len = 40;
	localparam int chain_len = 30;
	localparam int lu_groups = 8;
	localparam int mem_ops = 20;
	localparam int zero_len = 11;
	localparam int total_instr = reset_len + (prologue_len + random_len) +
		(prologue_len + chain_len) + (prologue_len + 1 + 3 * lu_groups) +
		(prologue_len + 1 + 8 + mem_ops) + (prologue_len + zero_len);
	localparam int timeout_limit = 2 * total_instr + 50;

	typedef struct packed {
		logic [xlen-1:0]       pc;
		logic                  we;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       data;
	} retire_rec_t;

	logic clock;
	logic reset;
	logic [xlen-1:0] inst_addr;
	logic [ilen-1:0] inst_data;
	logic retire_valid;
	logic [xlen-1:0] retire_pc;
	logic retire_we;
	logic [reg_addr_w-1:0] retire_rd;
	logic [xlen-1:0] retire_data;

	logic [ilen-1:0] imem [imem_depth];
	int prog_len = 0;
	logic [xlen-1:0] fetch_index;

	logic [xlen-1:0] model_regs [32];
	logic [xlen-1:0] model_mem [dmem_depth];
	retire_rec_t expected [$];
	int gaps [$];

	string test_name = "none";
	int cycle = 0;
	logic reset_q = 1'b1;
	int release_cycle = 0;
	int last_retire_cycle = 0;
	int retired = 0;
	int test_errors = 0;
	int error_total = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int unsigned rand_init;

	pipeline_top #(
		.reset_pc(reset_pc),
		.dmem_depth(dmem_depth)
	) UUT (
		.clock(clock), .reset(reset),
		.inst_addr(inst_addr), .inst_data(inst_data),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_we(retire_we),
		.retire_rd(retire_rd), .retire_data(retire_data)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// past the program the fetch sees addi x0,x0,0
	assign fetch_index = (inst_addr - reset_pc) >> 2;
	assign inst_data = (fetch_index < xlen'(prog_len)) ? imem[fetch_index[6:0]] : nop_word;

	always @(posedge clock) begin
		cycle = cycle + 1;
		reset_q = reset;
	end

	function automatic logic [ilen-1:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
			logic [4:0] rs1, logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [ilen-1:0] enc_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, op_imm};
	endfunction

	function automatic logic [ilen-1:0] enc_ld(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, 3'b011, rd, op_load};
	endfunction

	function automatic logic [ilen-1:0] enc_sd(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], op_store};
	endfunction

	function automatic logic [4:0] random_reg(int lo, int hi);
		return 5'(lo + $urandom % (hi - lo + 1));
	endfunction

	function automatic logic [ilen-1:0] random_alu_op(logic [4:0] rd, logic [4:0] rs1,
			logic [4:0] rs2);
		logic [11:0] imm;
		imm = 12'($urandom);
		case ($urandom % 6)
			0: return enc_r(7'b0000000, 3'b000, rd, rs1, rs2);
			1: return enc_r(7'b0100000, 3'b000, rd, rs1, rs2);
			2: return enc_r(7'b0000000, 3'b111, rd, rs1, rs2);
			3: return enc_r(7'b0000000, 3'b110, rd, rs1, rs2);
			4: return enc_r(7'b0000000, 3'b100, rd, rs1, rs2);
			default: return enc_addi(rd, rs1, imm);
		endcase
	endfunction

	function automatic int mem_index(logic [xlen-1:0] addr);
		return int'((addr >> 3) % dmem_depth);
	endfunction

	function automatic logic reads_reg(logic [ilen-1:0] word, logic [4:0] r);
		case (word[6:0])
			op_reg, op_store: return word[19:15] == r || word[24:20] == r;
			op_imm, op_load: return word[19:15] == r;
			default: return 1'b0;
		endcase
	endfunction

	// a load's nonzero rd read by the very next instruction costs one cycle
	function automatic int retire_gap(int i);
		logic [ilen-1:0] prev;
		if (i == 0)
			return 1;
		prev = imem[i - 1];
		if (prev[6:0] == op_load && prev[14:12] == 3'b011 && prev[11:7] != 5'd0 &&
				reads_reg(imem[i], prev[11:7]))
			return 2;
		return 1;
	endfunction

	// sequential execution of one instruction on the model state
	function automatic retire_rec_t model_step(logic [ilen-1:0] word, logic [xlen-1:0] pc);
		retire_rec_t rec;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] imm_i;
		logic [xlen-1:0] imm_s;
		logic [xlen-1:0] value;
		logic writes;
		a = model_regs[word[19:15]];
		b = model_regs[word[24:20]];
		imm_i = {{52{word[31]}}, word[31:20]};
		imm_s = {{52{word[31]}}, word[31:25], word[11:7]};
		value = '0;
		writes = 1'b0;
		case (word[6:0])
			op_reg: begin
				writes = 1'b1;
				case ({word[31:25], word[14:12]})
					10'b0000000_000: value = a + b;
					10'b0100000_000: value = a - b;
					10'b0000000_100: value = a ^ b;
					10'b0000000_110: value = a | b;
					10'b0000000_111: value = a & b;
					default: writes = 1'b0;
				endcase
			end
			op_imm: begin
				writes = (word[14:12] == 3'b000);
				value = a + imm_i;
			end
			op_load: begin
				writes = (word[14:12] == 3'b011);
				value = model_mem[mem_index(a + imm_i)];
			end
			op_store: begin
				if (word[14:12] == 3'b011)
					model_mem[mem_index(a + imm_s)] = b;
			end
			default: ;
		endcase
		rec.pc = pc;
		rec.rd = word[11:7];
		rec.we = writes && (word[11:7] != 5'd0);
		rec.data = value;
		if (rec.we)
			model_regs[rec.rd] = value;
		return rec;
	endfunction

	task automatic count_error();
		test_errors++;
		error_total++;
	endtask

	always @(negedge clock) begin
		retire_rec_t rec;
		int gap;
		int want_cycle;
		if (reset_q) begin
			if (retire_valid !== 1'b0) begin
				$display("test %s: retire_valid is not low while reset is held", test_name);
				count_error();
			end
		end else if (retire_valid === 1'b1) begin
			if (expected.size() == 0) begin
				if (retire_we !== 1'b0) begin
					$display("test %s: an instruction past the program wrote a register", test_name);
					count_error();
				end
			end else begin
				rec = expected.pop_front();
				gap = gaps.pop_front();
				want_cycle = (retired == 0) ? release_cycle + 4 : last_retire_cycle + gap;
				if (retire_pc !== rec.pc) begin
					$display("Error test %s pc: expected %h, actual %h", test_name, rec.pc, retire_pc);
					count_error();
				end
				if (retire_we !== rec.we) begin
					$display("Error test %s we at pc %h: expected %b, actual %b",
						test_name, rec.pc, rec.we, retire_we);
					count_error();
				end
				if (rec.we && retire_rd !== rec.rd) begin
					$display("Error test %s rd at pc %h: expected %0d, actual %0d",
						test_name, rec.pc, rec.rd, retire_rd);
					count_error();
				end
				if (rec.we && retire_data !== rec.data) begin
					$display("Error test %s data at pc %h: expected %h, actual %h",
						test_name, rec.pc, rec.data, retire_data);
					count_error();
				end
				if (cycle != want_cycle) begin
					$display("Error test %s retire cycle of pc %h: expected %0d, actual %0d",
						test_name, rec.pc, want_cycle, cycle);
					count_error();
				end
				last_retire_cycle = cycle;
				retired++;
			end
		end else if (retire_valid !== 1'b0) begin
			$display("test %s: retire_valid is unknown after reset", test_name);
			count_error();
		end
	end

	task automatic emit(logic [ilen-1:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	// every register the random code reads gets a known value first
	task automatic emit_prologue();
		int r;
		for (r = 1; r <= prologue_len; r++)
			emit(enc_addi(5'(r), 5'd0, 12'($urandom)));
	endtask

	task automatic start_test(input string name);
		@(posedge clock);
		#1 reset = 1'b1;
		@(posedge clock);
		#1;
		test_name = name;
		test_errors = 0;
		retired = 0;
		prog_len = 0;
	endtask

	task automatic finish_test();
		int i;
		for (i = 0; i < prog_len; i++) begin
			expected.push_back(model_step(imem[i], reset_pc + xlen'(4 * i)));
			gaps.push_back(retire_gap(i));
		end
		@(posedge clock);
		#1 reset = 1'b0;
		release_cycle = cycle;
		while (expected.size() != 0)
			@(posedge clock);
		@(posedge clock);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: ok, %0d instructions retired", test_name, retired);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, test_errors);
		end
	endtask

	task automatic run_reset_test();
		int r;
		start_test("reset");
		for (r = 1; r <= reset_len; r++)
			emit(enc_addi(5'(r), 5'd0, 12'($urandom)));
		finish_test();
	endtask

	task automatic run_random_test();
		int n;
		start_test("random_alu");
		emit_prologue();
		// sources and targets kept apart
		for (n = 0; n < random_len; n++)
			emit(random_alu_op(random_reg(8, 15), random_reg(0, 7), random_reg(0, 7)));
		finish_test();
	endtask

	task automatic run_forwarding_test();
		int n;
		logic [4:0] rd;
		logic [4:0] prev1;
		logic [4:0] prev2;
		start_test("forwarding");
		emit_prologue();
		prev1 = 5'd15;
		prev2 = 5'd14;
		for (n = 0; n < chain_len; n++) begin
			rd = random_reg(1, 15);
			if ($urandom % 2)
				emit(random_alu_op(rd, prev1, prev2));
			else
				emit(random_alu_op(rd, prev2, prev1));
			prev2 = prev1;
			prev1 = rd;
		end
		finish_test();
	endtask

	task automatic run_load_use_test();
		int g;
		logic [11:0] off;
		logic [4:0] dst;
		logic [4:0] other;
		logic [4:0] user_rd;
		start_test("load_use");
		emit_prologue();
		emit(enc_addi(5'd20, 5'd0, 12'd128));
		for (g = 0; g < lu_groups; g++) begin
			off = 12'(8 * g);
			dst = random_reg(1, 15);
			other = random_reg(1, 15);
			user_rd = random_reg(1, 15);
			emit(enc_sd(random_reg(1, 15), 5'd20, off));
			emit(enc_ld(dst, 5'd20, off));
			// the user reads the loaded register through a different operand each time
			case (g % 4)
				0: emit(enc_r(7'b0000000, 3'b000, user_rd, dst, other));
				1: emit(enc_r(7'b0100000, 3'b000, user_rd, other, dst));
				2: emit(enc_addi(user_rd, dst, 12'($urandom)));
				default: emit(enc_sd(dst, 5'd20, off));
			endcase
		end
		finish_test();
	endtask

	task automatic run_memory_test();
		int k;
		logic [11:0] off;
		start_test("store_load");
		emit_prologue();
		emit(enc_addi(5'd21, 5'd0, 12'd256));
		for (k = 0; k < 8; k++)
			emit(enc_sd(random_reg(1, 15), 5'd21, 12'(8 * k)));
		for (k = 0; k < mem_ops; k++) begin
			off = 12'(8 * ($urandom % 8));
			if ($urandom % 2)
				emit(enc_sd(random_reg(1, 15), 5'd21, off));
			else
				emit(enc_ld(random_reg(1, 15), 5'd21, off));
		end
		finish_test();
	endtask

	task automatic run_x0_test();
		start_test("x0_writes");
		emit_prologue();
		emit(enc_sd(5'd4, 5'd0, 12'd0));
		emit(enc_addi(5'd0, 5'd1, 12'd123));
		emit(enc_r(7'b0000000, 3'b000, 5'd5, 5'd0, 5'd6));
		emit(enc_r(7'b0000000, 3'b000, 5'd0, 5'd2, 5'd3));
		emit(enc_r(7'b0000000, 3'b110, 5'd8, 5'd0, 5'd0));
		emit(enc_ld(5'd0, 5'd0, 12'd0));
		emit(enc_r(7'b0000000, 3'b000, 5'd9, 5'd0, 5'd1));
		emit(enc_r(7'b0100000, 3'b000, 5'd10, 5'd0, 5'd1));
		emit(enc_addi(5'd0, 5'd0, 12'd77));
		emit(enc_addi(5'd11, 5'd0, 12'd0));
		emit(enc_r(7'b0000000, 3'b100, 5'd12, 5'd0, 5'd2));
		finish_test();
	endtask

	initial begin
		int r;
		rand_init = $urandom(32'hb64f9274);
		reset = 1'b1;
		for (r = 0; r < 32; r++)
			model_regs[r] = '0;
		run_reset_test();
		run_random_test();
		run_forwarding_test();
		run_load_use_test();
		run_memory_test();
		run_x0_test();
		$display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failed, error_total);
		if (tests_failed == 0 && error_total == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		wait (cycle >= timeout_limit);
		$display("timeout after %0d cycles in test %s", cycle, test_name);
		$display("tests failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/regfile.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/pipeline_top.sv
verification/pipeline_properties.sv
verification/pipeline_tb.sv
